// ==== serial_mem_pkg.sv ====
`default_nettype none

package serial_mem_pkg;

    localparam int DATA_W     = 64;
    localparam int BYTE_W     = 8;
    localparam int MEM_ADDR_W = 10;
    localparam int MAX_BYTES  = DATA_W / BYTE_W;
    localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;

    // index width of a byte lane inside one access word
    localparam int CNT_W      = $clog2(MAX_BYTES);

    // byte i of a word sits in bits 8i+7 down to 8i
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [BYTE_W-1:0]     byte_t;
    typedef logic [MEM_ADDR_W-1:0] addr_t;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    // byte count of an access is two to the power of the code
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } mem_size_e;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        WAIT_GRANT = 3'd1,
        TRANSFER   = 3'd2,
        DRAIN      = 3'd3, // only loads pass through here
        RETURN     = 3'd4
    } access_state_e;

endpackage

`default_nettype wire

// ==== mem_access_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit
    import serial_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  mem_op_e   op,
    input  mem_size_e size,
    input  addr_t     addr,
    input  data_t     wdata,
    input  logic      gnt,
    input  byte_t     bus_rdata,
    output logic      req,
    output addr_t     bus_addr,
    output logic      bus_we,
    output byte_t     bus_wdata,
    output data_t     rdata,
    output logic      done
);

    access_state_e state;
    access_state_e state_next;

    logic accept;

    // request captured on the start edge
    mem_op_e   op_q;
    mem_size_e size_q;
    data_t     wdata_q;

    addr_t            addr_cnt;
    logic [CNT_W-1:0] byte_cnt;  // lane of the byte being issued
    logic [CNT_W:0]   num_bytes;
    logic             last_byte;

    // a read issued last cycle whose byte shows up on bus_rdata now
    logic             rd_pending;
    logic [CNT_W-1:0] rd_idx;

    data_t stage;
    data_t stage_next;

    assign accept    = (state == IDLE) && start;
    assign num_bytes = {{CNT_W{1'b0}}, 1'b1} << size_q;
    assign last_byte = ({1'b0, byte_cnt} == num_bytes - 1'b1);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                if (gnt) begin
                    state_next = TRANSFER;
                end
            end
            TRANSFER: begin
                if (last_byte) begin
                    if (op_q == MEM_LOAD) begin
                        state_next = DRAIN; // one more cycle for the final read byte
                    end else begin
                        state_next = RETURN;
                    end
                end
            end
            DRAIN: begin
                state_next = RETURN;
            end
            RETURN: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= op;
            size_q  <= size;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt <= '0;
            byte_cnt <= '0;
        end else if (accept) begin
            addr_cnt <= addr;
            byte_cnt <= '0;
        end else if (state == TRANSFER) begin
            addr_cnt <= addr_cnt + 1'b1; // rolls over at the top of the RAM
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // the RAM answers one cycle after the address, so the lane index trails by one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
            rd_idx     <= '0;
        end else begin
            rd_pending <= (state == TRANSFER) && (op_q == MEM_LOAD);
            rd_idx     <= byte_cnt;
        end
    end

    always_comb begin
        stage_next = stage;
        if (rd_pending) begin
            stage_next[rd_idx*BYTE_W +: BYTE_W] = bus_rdata;
        end
    end

    // clearing on start leaves the unused upper bytes of narrow loads at zero
    always_ff @(posedge clk) begin
        if (accept) begin
            stage <= '0;
        end else begin
            stage <= stage_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (state == DRAIN) begin
            rdata <= stage_next; // includes the last byte arriving on this edge
        end
    end

    assign req       = (state == WAIT_GRANT) || (state == TRANSFER);
    assign bus_addr  = addr_cnt;
    assign bus_we    = (state == TRANSFER) && (op_q == MEM_STORE);
    assign bus_wdata = wdata_q[byte_cnt*BYTE_W +: BYTE_W]; // lowest byte goes out first
    assign done      = (state == RETURN);

endmodule

`default_nettype wire

// ==== byte_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_bus_arbiter (
    input  logic clk,
    input  logic rst_n,
    input  logic req_a,
    input  logic req_b,
    output logic gnt_a,
    output logic gnt_b
);

    logic hold_a;
    logic hold_b;
    logic gnt_a_next;
    logic gnt_b_next;
    logic last_b;       // set when port b got the most recent grant
    logic last_b_next;

    // an owner keeps the bus as long as its request stays up
    assign hold_a = gnt_a && req_a;
    assign hold_b = gnt_b && req_b;

    always_comb begin
        gnt_a_next  = 1'b0;
        gnt_b_next  = 1'b0;
        last_b_next = last_b;
        if (hold_a) begin
            gnt_a_next = 1'b1;
        end else if (hold_b) begin
            gnt_b_next = 1'b1;
        end else if (req_a && req_b) begin
            // a tie goes to whichever port was not served last
            if (last_b) begin
                gnt_a_next  = 1'b1;
                last_b_next = 1'b0;
            end else begin
                gnt_b_next  = 1'b1;
                last_b_next = 1'b1;
            end
        end else if (req_a) begin
            gnt_a_next  = 1'b1;
            last_b_next = 1'b0;
        end else if (req_b) begin
            gnt_b_next  = 1'b1;
            last_b_next = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_a  <= 1'b0;
            gnt_b  <= 1'b0;
            last_b <= 1'b0;
        end else begin
            gnt_a  <= gnt_a_next;
            gnt_b  <= gnt_b_next;
            last_b <= last_b_next;
        end
    end

endmodule

`default_nettype wire

// ==== byte_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_ram
    import serial_mem_pkg::*;
(
    input  logic  clk,
    input  addr_t addr,
    input  logic  we,
    input  byte_t wdata,
    output byte_t rdata
);

    byte_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, a write to the same address shows up a cycle later
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== serial_mem_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_mem_sys
    import serial_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      start_a,
    input  mem_op_e   op_a,
    input  mem_size_e size_a,
    input  addr_t     addr_a,
    input  data_t     wdata_a,
    output data_t     rdata_a,
    output logic      done_a,

    input  logic      start_b,
    input  mem_op_e   op_b,
    input  mem_size_e size_b,
    input  addr_t     addr_b,
    input  data_t     wdata_b,
    output data_t     rdata_b,
    output logic      done_b
);

    logic  req_a;
    logic  req_b;
    logic  gnt_a;
    logic  gnt_b;

    addr_t bus_addr_a;
    logic  bus_we_a;
    byte_t bus_wdata_a;
    addr_t bus_addr_b;
    logic  bus_we_b;
    byte_t bus_wdata_b;

    addr_t ram_addr;
    logic  ram_we;
    byte_t ram_wdata;
    byte_t ram_rdata;  // fans out to both units

    mem_access_unit u_port_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start_a),
        .op        (op_a),
        .size      (size_a),
        .addr      (addr_a),
        .wdata     (wdata_a),
        .gnt       (gnt_a),
        .bus_rdata (ram_rdata),
        .req       (req_a),
        .bus_addr  (bus_addr_a),
        .bus_we    (bus_we_a),
        .bus_wdata (bus_wdata_a),
        .rdata     (rdata_a),
        .done      (done_a)
    );

    mem_access_unit u_port_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start_b),
        .op        (op_b),
        .size      (size_b),
        .addr      (addr_b),
        .wdata     (wdata_b),
        .gnt       (gnt_b),
        .bus_rdata (ram_rdata),
        .req       (req_b),
        .bus_addr  (bus_addr_b),
        .bus_we    (bus_we_b),
        .bus_wdata (bus_wdata_b),
        .rdata     (rdata_b),
        .done      (done_b)
    );

    byte_bus_arbiter u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req_a (req_a),
        .req_b (req_b),
        .gnt_a (gnt_a),
        .gnt_b (gnt_b)
    );

    // the grant steers the bus, an idle bus never writes
    always_comb begin
        if (gnt_a) begin
            ram_addr  = bus_addr_a;
            ram_we    = bus_we_a;
            ram_wdata = bus_wdata_a;
        end else if (gnt_b) begin
            ram_addr  = bus_addr_b;
            ram_we    = bus_we_b;
            ram_wdata = bus_wdata_b;
        end else begin
            ram_addr  = bus_addr_a;
            ram_we    = 1'b0;
            ram_wdata = bus_wdata_a;
        end
    end

    byte_ram u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_serial_mem_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_serial_mem_sys
    import serial_mem_pkg::*;
();

    localparam int N_PAIRS         = 40;
    localparam int N_SEQ           = 160;
    localparam int NUM_OPS         = 22 + 2 * N_PAIRS + N_SEQ;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 2 * (MAX_BYTES + 4) + 20;
    localparam int DONE_LIMIT      = 4 * (MAX_BYTES + 4);  // cycles one access may take

    logic      clk;
    logic      rst_n;
    logic      start_a;
    mem_op_e   op_a;
    mem_size_e size_a;
    addr_t     addr_a;
    data_t     wdata_a;
    data_t     rdata_a;
    logic      done_a;
    logic      start_b;
    mem_op_e   op_b;
    mem_size_e size_b;
    addr_t     addr_b;
    data_t     wdata_b;
    data_t     rdata_b;
    logic      done_b;

    byte_t       model [MEM_DEPTH];  // mirror of the shared RAM
    logic        load_q_a[$];
    logic        load_q_b[$];
    data_t       exp_q_a[$];
    data_t       exp_q_b[$];
    int          mismatch_cnt = 0;
    int          fault_cnt = 0;
    int          load_cnt = 0;
    logic [31:0] rng_state = 32'hbf07;

    serial_mem_sys i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_a (start_a),
        .op_a    (op_a),
        .size_a  (size_a),
        .addr_a  (addr_a),
        .wdata_a (wdata_a),
        .rdata_a (rdata_a),
        .done_a  (done_a),
        .start_b (start_b),
        .op_b    (op_b),
        .size_b  (size_b),
        .addr_b  (addr_b),
        .wdata_b (wdata_b),
        .rdata_b (rdata_b),
        .done_b  (done_b)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // little-endian assembly from the model, bytes past the size stay zero
    function automatic data_t expected_load(input addr_t addr, input mem_size_e size);
        data_t result;
        addr_t a;
        int    i;
        result = '0;
        a = addr;
        for (i = 0; i < (1 << size); i++) begin
            result[i*BYTE_W +: BYTE_W] = model[a];
            a = a + 1'b1;  // wraps at the top of the RAM
        end
        return result;
    endfunction

    task automatic model_store(input addr_t addr, input mem_size_e size, input data_t wdata);
        addr_t a;
        int    i;
        a = addr;
        for (i = 0; i < (1 << size); i++) begin
            model[a] = wdata[i*BYTE_W +: BYTE_W];
            a = a + 1'b1;
        end
    endtask

    task automatic random_request(output mem_op_e op, output mem_size_e size,
                                  output int offset, output data_t word);
        rng_state = xorshift32(rng_state);
        op        = mem_op_e'(rng_state[0]);
        size      = mem_size_e'(rng_state[2:1]);
        offset    = int'(rng_state[31:8]);
        rng_state = xorshift32(rng_state);
        word[31:0] = rng_state;
        rng_state = xorshift32(rng_state);
        word[63:32] = rng_state;
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    // raises start on one port and records what its done must deliver
    task automatic drive_request(input logic port_b, input mem_op_e op, input mem_size_e size,
                                 input addr_t addr, input data_t wdata);
        if (op == MEM_STORE) begin
            model_store(addr, size, wdata);
        end
        if (port_b) begin
            start_b = 1'b1;
            op_b    = op;
            size_b  = size;
            addr_b  = addr;
            wdata_b = wdata;
            load_q_b.push_back(op == MEM_LOAD);
            exp_q_b.push_back(expected_load(addr, size));
        end else begin
            start_a = 1'b1;
            op_a    = op;
            size_a  = size;
            addr_a  = addr;
            wdata_a = wdata;
            load_q_a.push_back(op == MEM_LOAD);
            exp_q_a.push_back(expected_load(addr, size));
        end
    endtask

    task automatic release_start();
        @(negedge clk);
        start_a = 1'b0;
        start_b = 1'b0;
    endtask

    task automatic wait_done(input logic on_a, input logic on_b);
        logic seen_a;
        logic seen_b;
        int   cycles;
        seen_a = !on_a;
        seen_b = !on_b;
        cycles = 0;
        while (!(seen_a && seen_b) && cycles < DONE_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (done_a) seen_a = 1'b1;
            if (done_b) seen_b = 1'b1;
        end
        if (!seen_a) begin
            fault_cnt++;
            $display("port a gave no done within %0d cycles of its start", DONE_LIMIT);
        end
        if (!seen_b) begin
            fault_cnt++;
            $display("port b gave no done within %0d cycles of its start", DONE_LIMIT);
        end
        @(negedge clk);  // unit is back in IDLE one cycle after done
    endtask

    task automatic run_op(input logic port_b, input mem_op_e op, input mem_size_e size,
                          input addr_t addr, input data_t wdata);
        drive_request(port_b, op, size, addr, wdata);
        release_start();
        wait_done(!port_b, port_b);
    endtask

    task automatic check_done(input logic port_b);
        logic  is_load;
        data_t exp;
        if (port_b ? (load_q_b.size() == 0) : (load_q_a.size() == 0)) begin
            fault_cnt++;
            $display("port %s raised done with no request outstanding", port_b ? "b" : "a");
        end else if (port_b) begin
            is_load = load_q_b.pop_front();
            exp     = exp_q_b.pop_front();
            if (is_load) begin
                load_cnt++;
                check_data("rdata_b", exp, rdata_b);
            end
        end else begin
            is_load = load_q_a.pop_front();
            exp     = exp_q_a.pop_front();
            if (is_load) begin
                load_cnt++;
                check_data("rdata_a", exp, rdata_a);
            end
        end
    endtask

    // outputs are settled by the falling edge, one done per pulse
    always @(negedge clk) begin
        if (rst_n) begin
            if (done_a) check_done(1'b0);
            if (done_b) check_done(1'b1);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fault_cnt++;
        $display("run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("summary: %0d loads compared, %0d mismatches, %0d other errors",
                 load_cnt, mismatch_cnt, fault_cnt);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        mem_op_e   rop;
        mem_size_e rsize;
        int        roff;
        data_t     rword;
        int        n;
        int        s;
        rst_n   = 1'b0;
        start_a = 1'b0;
        op_a    = MEM_LOAD;
        size_a  = SIZE_BYTE;
        addr_a  = '0;
        wdata_a = '0;
        start_b = 1'b0;
        op_b    = MEM_LOAD;
        size_b  = SIZE_BYTE;
        addr_b  = '0;
        wdata_b = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (5) begin
            @(negedge clk);
            check_flag("done_a", 1'b0, done_a);
            check_flag("done_b", 1'b0, done_b);
            check_data("rdata_a", data_t'(0), rdata_a);
            check_data("rdata_b", data_t'(0), rdata_b);
        end

        // widest first, so narrow loads find stale upper bytes in the RAM
        for (s = 3; s >= 0; s--) begin
            random_request(rop, rsize, roff, rword);
            run_op(1'b0, MEM_STORE, mem_size_e'(s), addr_t'(16), rword);
            run_op(1'b0, MEM_LOAD, mem_size_e'(s), addr_t'(16), '0);
        end
        for (s = 3; s >= 0; s--) begin
            random_request(rop, rsize, roff, rword);
            run_op(1'b1, MEM_STORE, mem_size_e'(s), addr_t'(48), rword);
            run_op(1'b1, MEM_LOAD, mem_size_e'(s), addr_t'(48), '0);
        end
        random_request(rop, rsize, roff, rword);
        run_op(1'b0, MEM_STORE, SIZE_DOUBLE, addr_t'(96), rword);
        run_op(1'b1, MEM_LOAD, SIZE_DOUBLE, addr_t'(96), '0);
        run_op(1'b1, MEM_LOAD, SIZE_HALF, addr_t'(99), '0);

        random_request(rop, rsize, roff, rword);
        run_op(1'b0, MEM_STORE, SIZE_DOUBLE, addr_t'(1020), rword);
        run_op(1'b0, MEM_LOAD, SIZE_DOUBLE, addr_t'(1020), '0);
        run_op(1'b1, MEM_LOAD, SIZE_WORD, addr_t'(0), '0);  // upper half landed at 0

        for (n = 0; n < N_PAIRS; n++) begin
            random_request(rop, rsize, roff, rword);
            drive_request(1'b0, rop, rsize, addr_t'(256 + roff % 40), rword);
            random_request(rop, rsize, roff, rword);
            drive_request(1'b1, rop, rsize, addr_t'(640 + roff % 40), rword);
            release_start();
            wait_done(1'b1, 1'b1);
        end

        // overlapping window around the top of the RAM, ports take turns
        for (n = 0; n < N_SEQ; n++) begin
            random_request(rop, rsize, roff, rword);
            run_op(n[0], rop, rsize, addr_t'(1000 + roff % 48), rword);
        end

        if (load_q_a.size() != 0 || load_q_b.size() != 0) begin
            fault_cnt++;
            $display("requests still waiting for done at the end of the run");
        end
        $display("summary: %0d loads compared, %0d mismatches, %0d other errors",
                 load_cnt, mismatch_cnt, fault_cnt);
        if (mismatch_cnt == 0 && fault_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== serial_mem_sys.f ====
serial_mem_pkg.sv
mem_access_unit.sv
byte_bus_arbiter.sv
byte_ram.sv
serial_mem_sys.sv
tb_serial_mem_sys.sv

// ==== Bender.yml ====
package:
  name: serial_mem_sys

sources:
  - files:
      - serial_mem_pkg.sv
      - mem_access_unit.sv
      - byte_bus_arbiter.sv
      - byte_ram.sv
      - serial_mem_sys.sv
  - target: simulation
    files:
      - tb_serial_mem_sys.sv
